// File: flist.f
+incdir+hdl
hdl/lsu_req_pkg.sv
hdl/lsu_rf_pkg.sv
hdl/lsu_info_fifo.sv
hdl/lsu_rsp_collector.sv
hdl/lsu_wb_sequencer.sv
hdl/lsu_wb_router.sv
hdl/lsu_wb_top.sv
verif/lsu_wb_tb.sv

// File: verif/lsu_wb_tb.sv
//##########################################################
// lsu writeback testbench
// directed tests on the writeback path, a monitor that
// logs writes and done reports, and a watchdog
//##########################################################

`timescale 1ns/1ps
`include "lsu_wb_defines.svh"

module lsu_wb_tb
   import lsu_req_pkg::*;
   import lsu_rf_pkg::*;
();

   // beats over all tests for the watchdog
   localparam int TOTAL_BEATS = 70;

   logic                       clk;
   logic                       arst_n;
   logic                       req_push;
   lsu_req_info_t              req_info;
   logic                       info_full;
   logic                       rsp_beat_valid;
   logic [`LSU_BEAT_WIDTH-1:0] rsp_beat_data;
   logic                       wb_en;
   sgpr_wr_t                   sgpr_wr;
   vgpr_wr_t                   vgpr_wr;
   instr_done_t                sgpr_done;
   instr_done_t                vgpr_done;
   retire_info_t               retire_info;
   logic                       rfa_dest_wr_req;

   // monitor logs cleared at the start of each test
   sgpr_wr_t                   sgpr_log[$];
   vgpr_wr_t                   vgpr_log[$];
   instr_done_t                sdone_log[$];
   instr_done_t                vdone_log[$];
   retire_info_t               retire_log[$];
   logic                       rfa_log[$];
   logic                       vdone_at_wr[$];
   // beats sent in the current test in order
   logic [`LSU_BEAT_WIDTH-1:0] sent[$];
   logic [31:0]                rng = 32'h2427;
   string                      cur_test;
   int                         test_errs = 0;
   int                         n_pass = 0;
   int                         n_fail = 0;

   lsu_wb_top u_lsu_wb_top (.*);

   always #4 clk = ~clk;

   // write ports sampled on the rising edge that ends their cycle
   always @(posedge clk)
   begin
      if (|sgpr_wr.wr_en)
         sgpr_log.push_back(sgpr_wr);
      if (vgpr_wr.wr_en)
      begin
         vgpr_log.push_back(vgpr_wr);
         vdone_at_wr.push_back(vgpr_done.valid);
      end
      // rfa logged on any write cycle or wherever it shows up alone
      if (rfa_dest_wr_req || (|sgpr_wr.wr_en) || vgpr_wr.wr_en)
         rfa_log.push_back(rfa_dest_wr_req);
      if (sgpr_done.valid)
         sdone_log.push_back(sgpr_done);
      if (vgpr_done.valid)
         vdone_log.push_back(vgpr_done);
      if (sgpr_done.valid || vgpr_done.valid)
         retire_log.push_back(retire_info);
   end

   initial
   begin
      #(TOTAL_BEATS * 8 + 1600);
      $display("watchdog expired before the tests finished");
      $display("Test failed");
      $finish;
   end

   // xorshift32 step
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // four fresh words per beat
   function automatic logic [`LSU_BEAT_WIDTH-1:0] next_beat();
      logic [`LSU_BEAT_WIDTH-1:0] b;
      for (int i = 0; i < 4; i++)
      begin
         rng           = xorshift(rng);
         b[i*32 +: 32] = rng;
      end
      return b;
   endfunction

   // one vgpr register from sixteen sent beats with the first lowest
   function automatic logic [`LSU_VGPR_WIDTH-1:0] slice_of(input int first);
      logic [`LSU_VGPR_WIDTH-1:0] s;
      for (int j = 0; j < `LSU_BEATS_PER_VSLICE; j++)
         s[j*`LSU_BEAT_WIDTH +: `LSU_BEAT_WIDTH] = sent[first + j];
      return s;
   endfunction

   // one nibble each for sgpr writes, vgpr writes, rfa cycles, sgpr and vgpr dones
   function automatic logic [19:0] log_sizes();
      return {4'(sgpr_log.size()), 4'(vgpr_log.size()), 4'(rfa_log.size()),
              4'(sdone_log.size()), 4'(vdone_log.size())};
   endfunction

   task automatic report(input string what, input logic [$bits(vgpr_wr_t)-1:0] e,
                         input logic [$bits(vgpr_wr_t)-1:0] a);
      $display("Error %s: %s expected %0h actual %0h", cur_test, what, e, a);
      test_errs++;
   endtask

   task automatic check_value(input string what, input logic [31:0] e, input logic [31:0] a);
      if (e !== a)
         report(what, e, a);
   endtask

   task automatic compare_sgpr(input sgpr_wr_t e, input sgpr_wr_t a);
      if (e !== a)
         report("sgpr write", e, a);
   endtask

   task automatic compare_vgpr(input vgpr_wr_t e, input vgpr_wr_t a);
      if (e !== a)
         report("vgpr write", e, a);
   endtask

   task automatic compare_done(input instr_done_t e, input instr_done_t a);
      if (e !== a)
         report("done report", e, a);
   endtask

   task automatic compare_retire(input retire_info_t e, input retire_info_t a);
      if (e !== a)
         report("retire info", e, a);
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
      sgpr_log.delete();
      vgpr_log.delete();
      sdone_log.delete();
      vdone_log.delete();
      retire_log.delete();
      rfa_log.delete();
      vdone_at_wr.delete();
      sent.delete();
   endtask

   task automatic end_test();
      if (test_errs == 0)
         n_pass++;
      else
         n_fail++;
      $display("%s %s, %0d errors", cur_test, (test_errs == 0) ? "pass" : "FAIL", test_errs);
   endtask

   // all drive tasks start and end on a falling edge
   task automatic push_req(input lsu_req_info_t info);
      req_push = 1'b1;
      req_info = info;
      @(negedge clk);
      req_push = 1'b0;
   endtask

   task automatic send_beats(input int n);
      logic [`LSU_BEAT_WIDTH-1:0] b;
      for (int i = 0; i < n; i++)
      begin
         b = next_beat();
         sent.push_back(b);
         rsp_beat_valid = 1'b1;
         rsp_beat_data  = b;
         @(negedge clk);
      end
      rsp_beat_valid = 1'b0;
   endtask

   // wait for n done reports after the last beat
   task automatic wait_done(input int n);
      int cyc;
      cyc = 0;
      while ((sdone_log.size() + vdone_log.size() < n) && (cyc < 20))
      begin
         @(negedge clk);
         cyc++;
      end
      if (sdone_log.size() + vdone_log.size() < n)
      begin
         $display("%s: done report did not arrive within 20 cycles", cur_test);
         test_errs++;
      end
      // catch a repeated done
      repeat (3) @(negedge clk);
   endtask

   task automatic test_reset();
      start_test("reset");
      check_value("enables, dones, rfa, full", 0, {sgpr_wr.wr_en, vgpr_wr.wr_en,
                  sgpr_done.valid, vgpr_done.valid, rfa_dest_wr_req, info_full});
      end_test();
   endtask

   task automatic test_sgpr_load();
      lsu_req_info_t info;
      info = '{6'd5, 1'b1, LSU_DEST_SGPR, 10'h3a5, 4'b0011, '1, 32'h0000_1040, 1'b1};
      start_test("sgpr_load");
      push_req(info);
      send_beats(1);
      wait_done(1);
      check_value("log sizes", 20'h1_0_1_1_0, log_sizes());
      if (test_errs == 0)
      begin
         // sgpr address is the low 9 bits of dest_addr
         compare_sgpr(sgpr_wr_t'{info.dest_addr[8:0], sent[0], 4'b0011}, sgpr_log[0]);
         check_value("rfa during write", 1, rfa_log[0]);
         compare_done(instr_done_t'{1'b1, info.wfid}, sdone_log[0]);
         compare_retire(retire_info_t'{info.instr_pc, info.gm_or_lds}, retire_log[0]);
      end
      end_test();
   endtask

   task automatic test_vgpr_load();
      lsu_req_info_t info;
      info = '{6'd12, 1'b1, LSU_DEST_VGPR, 10'h120, 4'b0011,
               64'hf0f0_0ff0_a5a5_3c3c, 32'h0000_2000, 1'b0};
      start_test("vgpr_load_x2");
      push_req(info);
      send_beats(32);
      wait_done(1);
      check_value("log sizes", 20'h0_2_2_0_1, log_sizes());
      if (test_errs == 0)
      begin
         // one register per dword at consecutive addresses
         for (int k = 0; k < 2; k++)
            compare_vgpr(vgpr_wr_t'{info.dest_addr + 10'(k), slice_of(16 * k), 1'b1,
                                    info.exec_mask}, vgpr_log[k]);
         check_value("done with last write", 2'b10, {vdone_at_wr[1], vdone_at_wr[0]});
         check_value("rfa during writes", 2'b11, {rfa_log[1], rfa_log[0]});
         compare_done(instr_done_t'{1'b1, info.wfid}, vdone_log[0]);
         compare_retire(retire_info_t'{info.instr_pc, info.gm_or_lds}, retire_log[0]);
      end
      end_test();
   endtask

   task automatic test_store_none();
      lsu_req_info_t st;
      lsu_req_info_t none;
      // store carries dword enables that must still write nothing
      st   = '{6'd7, 1'b0, LSU_DEST_SGPR, 10'h010, 4'b1111, '1, 32'h0000_3000, 1'b1};
      none = '{6'd9, 1'b1, LSU_DEST_NONE, 10'h020, 4'b1111, '1, 32'h0000_3004, 1'b0};
      start_test("store_and_none");
      push_req(st);
      send_beats(1);
      wait_done(1);
      // none entry reports nothing within the fixed two cycle latency
      push_req(none);
      send_beats(1);
      repeat (6) @(negedge clk);
      check_value("log sizes", 20'h0_0_0_1_0, log_sizes());
      if (test_errs == 0)
      begin
         compare_done(instr_done_t'{1'b1, st.wfid}, sdone_log[0]);
         compare_retire(retire_info_t'{st.instr_pc, st.gm_or_lds}, retire_log[0]);
      end
      end_test();
   endtask

   // only passes if the none entry above left the queue
   task automatic test_wb_en_low();
      lsu_req_info_t info;
      info = '{6'd33, 1'b1, LSU_DEST_VGPR, 10'h200, 4'b0001,
               64'h0000_ffff_0000_ffff, 32'h0000_4000, 1'b0};
      start_test("wb_en_low");
      wb_en = 1'b0;
      push_req(info);
      send_beats(16);
      wait_done(1);
      wb_en = 1'b1;
      check_value("log sizes", 20'h0_0_0_0_1, log_sizes());
      if (test_errs == 0)
         compare_done(instr_done_t'{1'b1, info.wfid}, vdone_log[0]);
      end_test();
   endtask

   task automatic test_pipeline();
      lsu_req_info_t reqs[4];
      reqs[0] = '{6'd1, 1'b1, LSU_DEST_SGPR, 10'h004, 4'b1111, '1, 32'h0000_5000, 1'b1};
      reqs[1] = '{6'd2, 1'b1, LSU_DEST_VGPR, 10'h040, 4'b0001,
                  64'h1234_5678_9abc_def0, 32'h0000_5004, 1'b0};
      reqs[2] = '{6'd3, 1'b0, LSU_DEST_VGPR, 10'h080, 4'b0011, '1, 32'h0000_5008, 1'b1};
      reqs[3] = '{6'd4, 1'b1, LSU_DEST_SGPR, 10'h00c, 4'b0001, '1, 32'h0000_500c, 1'b0};
      start_test("pipeline");
      // nothing pops before the beats so full rises with the fourth entry
      for (int i = 0; i < 4; i++)
      begin
         check_value("info_full before push", 0, info_full);
         push_req(reqs[i]);
      end
      check_value("info_full with four queued", 1, info_full);
      // sgpr beat then 16 vgpr beats then store ack and sgpr beat without gaps
      send_beats(19);
      wait_done(4);
      check_value("log sizes", 20'h2_1_3_2_2, log_sizes());
      if (test_errs == 0)
      begin
         compare_sgpr(sgpr_wr_t'{9'h004, sent[0], 4'b1111}, sgpr_log[0]);
         compare_vgpr(vgpr_wr_t'{10'h040, slice_of(1), 1'b1, reqs[1].exec_mask}, vgpr_log[0]);
         compare_sgpr(sgpr_wr_t'{9'h00c, sent[18], 4'b0001}, sgpr_log[1]);
         compare_done(instr_done_t'{1'b1, 6'd1}, sdone_log[0]);
         compare_done(instr_done_t'{1'b1, 6'd4}, sdone_log[1]);
         compare_done(instr_done_t'{1'b1, 6'd2}, vdone_log[0]);
         compare_done(instr_done_t'{1'b1, 6'd3}, vdone_log[1]);
         // retire order follows request order
         for (int i = 0; i < 4; i++)
            compare_retire(retire_info_t'{reqs[i].instr_pc, reqs[i].gm_or_lds}, retire_log[i]);
      end
      end_test();
   endtask

   initial
   begin
      clk            = 1'b0;
      arst_n         = 1'b0;
      req_push       = 1'b0;
      req_info       = '0;
      rsp_beat_valid = 1'b0;
      rsp_beat_data  = '0;
      wb_en          = 1'b1;
      // outputs checked while reset is held for two cycles
      repeat (2) @(negedge clk);
      test_reset();
      arst_n = 1'b1;
      @(negedge clk);
      test_sgpr_load();
      test_vgpr_load();
      test_store_none();
      test_wb_en_low();
      test_pipeline();
      $display("tests passed %0d, tests failing %0d", n_pass, n_fail);
      if (n_fail == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: hdl/lsu_wb_top.sv
//##########################################################
// lsu writeback top
// info queue, response collector, sequencer and router
//##########################################################

`timescale 1ns/1ps
`include "lsu_wb_defines.svh"

module lsu_wb_top
   import lsu_req_pkg::*;
   import lsu_rf_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       req_push,
   input  lsu_req_info_t              req_info,
   output logic                       info_full,
   input  logic                       rsp_beat_valid,
   input  logic [`LSU_BEAT_WIDTH-1:0] rsp_beat_data,
   input  logic                       wb_en,
   output sgpr_wr_t                   sgpr_wr,
   output vgpr_wr_t                   vgpr_wr,
   output instr_done_t                sgpr_done,
   output instr_done_t                vgpr_done,
   output retire_info_t               retire_info,
   output logic                       rfa_dest_wr_req
);

   lsu_req_info_t              head_info;
   logic                       head_valid;
   logic                       info_pop;
   logic                       slice_done;
   logic [1:0]                 slice_index;
   logic [`LSU_VGPR_WIDTH-1:0] slice_data;
   logic                       wb_ack;
   logic [1:0]                 incr_addr;
   logic [`LSU_VGPR_WIDTH-1:0] wb_data;
   logic                       retire_now;

   lsu_info_fifo u_info_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (req_push),
      .push_info  (req_info),
      .pop        (info_pop),
      .head_info  (head_info),
      .head_valid (head_valid),
      .full       (info_full)
   );

   lsu_rsp_collector u_rsp_collector (
      .clk         (clk),
      .arst_n      (arst_n),
      .beat_valid  (rsp_beat_valid),
      .beat_data   (rsp_beat_data),
      .head_info   (head_info),
      .head_valid  (head_valid),
      .info_pop    (info_pop),
      .slice_done  (slice_done),
      .slice_index (slice_index),
      .slice_data  (slice_data)
   );

   lsu_wb_sequencer u_wb_sequencer (
      .clk         (clk),
      .arst_n      (arst_n),
      .slice_done  (slice_done),
      .slice_index (slice_index),
      .slice_data  (slice_data),
      .head_info   (head_info),
      .wb_ack      (wb_ack),
      .incr_addr   (incr_addr),
      .wb_data     (wb_data),
      .retire_now  (retire_now),
      .info_pop    (info_pop)
   );

   // head info still valid here, pop lands at the end of this step
   lsu_wb_router u_wb_router (
      .wb_ack          (wb_ack),
      .info            (head_info),
      .rd_data         (wb_data),
      .wb_en           (wb_en),
      .incr_addr       (incr_addr),
      .retire          (retire_now),
      .sgpr_wr         (sgpr_wr),
      .vgpr_wr         (vgpr_wr),
      .sgpr_done       (sgpr_done),
      .vgpr_done       (vgpr_done),
      .retire_info     (retire_info),
      .rfa_dest_wr_req (rfa_dest_wr_req)
   );

endmodule

// File: hdl/lsu_wb_router.sv
//##########################################################
// lsu writeback router
// decodes destination, drives sgpr/vgpr write ports,
// done reports and retire info
//##########################################################

`timescale 1ns/1ps
`include "lsu_wb_defines.svh"

module lsu_wb_router
   import lsu_req_pkg::*;
   import lsu_rf_pkg::*;
(
   input  logic                       wb_ack,
   input  lsu_req_info_t              info,
   input  logic [`LSU_VGPR_WIDTH-1:0] rd_data,
   input  logic                       wb_en,
   input  logic [1:0]                 incr_addr,
   input  logic                       retire,
   output sgpr_wr_t                   sgpr_wr,
   output vgpr_wr_t                   vgpr_wr,
   output instr_done_t                sgpr_done,
   output instr_done_t                vgpr_done,
   output retire_info_t               retire_info,
   output logic                       rfa_dest_wr_req
);

   always_comb
   begin
      // payload follows the head unconditionally
      sgpr_wr.addr    = info.dest_addr[8:0];
      sgpr_wr.data    = rd_data[`LSU_SGPR_DATA_WIDTH-1:0];
      sgpr_wr.wr_en   = 4'b0;
      vgpr_wr.addr    = info.dest_addr + 10'(incr_addr);
      vgpr_wr.data    = rd_data;
      vgpr_wr.wr_en   = 1'b0;
      vgpr_wr.wr_mask = info.exec_mask;
      sgpr_done.valid = 1'b0;
      sgpr_done.wfid  = info.wfid;
      vgpr_done.valid = 1'b0;
      vgpr_done.wfid  = info.wfid;

      // ack, load/store, destination kind
      casez ({wb_ack, info.ld1_st0, info.dest_kind})
         4'b1_1_10:
         begin
            // vgpr load, writes suppressed while wb_en low
            vgpr_wr.wr_en   = (|info.reg_wr_en) & wb_en;
            vgpr_done.valid = retire;
         end
         4'b1_1_11:
         begin
            sgpr_wr.wr_en   = info.reg_wr_en & {4{wb_en}};
            sgpr_done.valid = retire;
         end
         4'b1_0_10:
         begin
            // store ack, done only
            vgpr_done.valid = retire;
         end
         4'b1_0_11:
         begin
            sgpr_done.valid = retire;
         end
         default:
         begin
            // no ack or none destination, nothing written
            sgpr_wr.wr_en = 4'b0;
         end
      endcase

      retire_info.pc        = info.instr_pc;
      retire_info.gm_or_lds = info.gm_or_lds;

      rfa_dest_wr_req = (|sgpr_wr.wr_en) | vgpr_wr.wr_en;
   end

endmodule

// File: hdl/lsu_wb_sequencer.sv
//##########################################################
// lsu writeback sequencer
// one registered writeback step per slice, retires and
// pops the head on its last slice
//##########################################################

`timescale 1ns/1ps
`include "lsu_wb_defines.svh"

module lsu_wb_sequencer
   import lsu_req_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       slice_done,
   input  logic [1:0]                 slice_index,
   input  logic [`LSU_VGPR_WIDTH-1:0] slice_data,
   input  lsu_req_info_t              head_info,
   output logic                       wb_ack,
   output logic [1:0]                 incr_addr,
   output logic [`LSU_VGPR_WIDTH-1:0] wb_data,
   output logic                       retire_now,
   output logic                       info_pop
);

   logic [2:0] n_slices;
   logic       last_slice;

   // popcount of reg_wr_en for vgpr loads, otherwise one
   assign n_slices = lsu_slice_count(head_info);

   // slice_index counts from 0
   assign last_slice = ({1'b0, slice_index} == (n_slices - 3'd1));

   // slice data, register offset and ack travel together
   // so the router sees a consistent step
   always_ff @(posedge clk)
   begin
      if (slice_done)
         wb_data <= slice_data;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wb_ack     <= 1'b0;
         incr_addr  <= '0;
         retire_now <= 1'b0;
      end
      else
      begin
         // one cycle per slice, no back-pressure
         wb_ack     <= slice_done;
         retire_now <= slice_done && last_slice;
         // vgpr register offset, dest_addr plus slice
         if (slice_done)
            incr_addr <= slice_index;
      end
   end

   // pop once per instruction, in the retire cycle
   // head stays put while the router reads it
   assign info_pop = retire_now;

endmodule

// File: hdl/lsu_rsp_collector.sv
//##########################################################
// lsu response collector
// shifts 128-bit beats into a slice buffer, hands full
// slices to the sequencer through a hold register
//##########################################################

`timescale 1ns/1ps
`include "lsu_wb_defines.svh"

module lsu_rsp_collector
   import lsu_req_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       beat_valid,
   input  logic [`LSU_BEAT_WIDTH-1:0] beat_data,
   input  lsu_req_info_t              head_info,
   input  logic                       head_valid,
   input  logic                       info_pop,
   output logic                       slice_done,
   output logic [1:0]                 slice_index,
   output logic [`LSU_VGPR_WIDTH-1:0] slice_data
);

   localparam int BEAT_W  = `LSU_BEAT_WIDTH;
   localparam int SLICE_W = `LSU_VGPR_WIDTH;
   localparam int NBEATS  = `LSU_BEATS_PER_VSLICE;
   localparam int CNT_W   = $clog2(NBEATS + 1);

   logic [SLICE_W-1:0] shift_buf;
   logic [SLICE_W-1:0] shift_next;
   logic [SLICE_W-1:0] hold_buf;
   logic [CNT_W-1:0]   pend_cnt;
   logic [CNT_W-1:0]   cnt_now;
   logic [CNT_W-1:0]   need;
   logic [CNT_W-1:0]   old_idx;
   logic [BEAT_W-1:0]  old_beat;
   logic [2:0]         slice_cnt;
   logic               is_vload;
   logic               head_done;
   logic               fire;

   // new beat enters at the top, beat 0 ends up lowest
   assign shift_next = beat_valid ? {beat_data, shift_buf[SLICE_W-1:BEAT_W]} : shift_buf;
   assign cnt_now    = pend_cnt + CNT_W'(beat_valid);

   // 16 beats for a vgpr load, one for sgpr, store ack or none
   assign is_vload = head_info.ld1_st0 && (head_info.dest_kind == LSU_DEST_VGPR);
   assign need     = is_vload ? CNT_W'(NBEATS) : CNT_W'(1);

   // oldest unassigned beat, used by single beat slices
   assign old_idx  = CNT_W'(NBEATS) - cnt_now;
   assign old_beat = shift_next[old_idx[CNT_W-2:0]*BEAT_W +: BEAT_W];

   // head fully collected, waiting for its pop
   // beats of the next request just pile up until then
   assign head_done = (slice_cnt == lsu_slice_count(head_info));
   assign fire      = head_valid && !head_done && (cnt_now >= need);

   always_ff @(posedge clk)
   begin
      if (beat_valid)
         shift_buf <= shift_next;
      // hold frees the shift buffer for the next slice
      if (fire)
         hold_buf <= is_vload ? shift_next : {{(SLICE_W - BEAT_W){1'b0}}, old_beat};
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pend_cnt    <= '0;
         slice_cnt   <= '0;
         slice_done  <= 1'b0;
         slice_index <= '0;
      end
      else
      begin
         slice_done <= fire;
         pend_cnt   <= fire ? cnt_now - need : cnt_now;
         // slice counter is per instruction
         if (info_pop)
            slice_cnt <= '0;
         else if (fire)
            slice_cnt <= slice_cnt + 3'd1;
         if (fire)
            slice_index <= slice_cnt[1:0];
      end
   end

   assign slice_data = hold_buf;

endmodule

// File: hdl/lsu_info_fifo.sv
//##########################################################
// lsu info queue
// in-order queue of request info waiting for memory data
//##########################################################

`timescale 1ns/1ps
`include "lsu_wb_defines.svh"

module lsu_info_fifo
   import lsu_req_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          push,
   input  lsu_req_info_t push_info,
   input  logic          pop,
   output lsu_req_info_t head_info,
   output logic          head_valid,
   output logic          full
);

   localparam int DEPTH = `LSU_INFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   lsu_req_info_t    mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // issuer watches full, a push into a full queue is dropped
   assign do_push    = push && !full;
   assign do_pop     = pop && head_valid;
   assign full       = (count == CNT_W'(DEPTH));
   assign head_valid = (count != '0);
   // head visible without popping
   assign head_info  = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_info;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // pointers wrap at depth
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: hdl/lsu_rf_pkg.sv
//##########################################################
// lsu register file types
// sgpr/vgpr write ports, done reports and retire info
//##########################################################

`include "lsu_wb_defines.svh"

package lsu_rf_pkg;

   // scalar write, up to four dwords in one cycle
   typedef struct packed {
      logic [8:0]                      addr;
      logic [`LSU_SGPR_DATA_WIDTH-1:0] data;
      logic [3:0]                      wr_en;
   } sgpr_wr_t;

   // vector write, one full register per cycle
   typedef struct packed {
      logic [9:0]                 addr;
      logic [`LSU_VGPR_WIDTH-1:0] data;
      logic                       wr_en;
      // lane mask, straight from exec
      logic [63:0]                wr_mask;
   } vgpr_wr_t;

   // profiler done report
   typedef struct packed {
      logic                       valid;
      logic [`LSU_WFID_WIDTH-1:0] wfid;
   } instr_done_t;

   // trace monitor retire info
   typedef struct packed {
      logic [31:0] pc;
      logic        gm_or_lds;
   } retire_info_t;

endpackage

// File: hdl/lsu_req_pkg.sv
//##########################################################
// lsu request types
// outstanding memory request info and destination kind
//##########################################################

`include "lsu_wb_defines.svh"

package lsu_req_pkg;

   // upper two bits of the reference lddst address
   // 2'b00 and 2'b01 write nothing
   typedef enum logic [1:0] {
      LSU_DEST_NONE     = 2'b00,
      LSU_DEST_NONE_ALT = 2'b01,
      LSU_DEST_VGPR     = 2'b10,
      LSU_DEST_SGPR     = 2'b11
   } lsu_dest_e;

   typedef struct packed {
      logic [`LSU_WFID_WIDTH-1:0] wfid;
      logic                       ld1_st0;
      lsu_dest_e                  dest_kind;
      logic [9:0]                 dest_addr;
      // loaded dwords, contiguous from bit 0
      logic [3:0]                 reg_wr_en;
      logic [63:0]                exec_mask;
      logic [31:0]                instr_pc;
      logic                       gm_or_lds;
   } lsu_req_info_t;

   // slices per instruction
   // one per loaded dword for a vgpr load, otherwise a single slice
   function automatic logic [2:0] lsu_slice_count(lsu_req_info_t info);
      logic [2:0] n;
      n = 3'd0;
      for (int i = 0; i < 4; i++)
      begin
         n = n + 3'(info.reg_wr_en[i]);
      end
      if (info.ld1_st0 && (info.dest_kind == LSU_DEST_VGPR) && (n != 3'd0))
      begin
         return n;
      end
      return 3'd1;
   endfunction

endpackage

// File: hdl/lsu_wb_defines.svh
//##########################################################
// lsu writeback defines
// widths, beat counts and queue depth shared by the
// load/store writeback path
//##########################################################

`ifndef LSU_WB_DEFINES_SVH
`define LSU_WB_DEFINES_SVH

// one memory response beat
`define LSU_BEAT_WIDTH 128

// one vector register, 64 lanes of 32 bits
`define LSU_VGPR_WIDTH 2048

// sgpr write port carries four dwords
`define LSU_SGPR_DATA_WIDTH 128

// beats per vgpr slice, vgpr width over beat width
`define LSU_BEATS_PER_VSLICE 16

// outstanding requests
`define LSU_INFO_DEPTH 4

`define LSU_WFID_WIDTH 6

`endif
